/* design/bpu_cfg_pkg.sv */
package bpu_cfg_pkg;

    // default geometry of the predictor
    // bpu_top takes these as parameter defaults and hands them down

    // first fetch address after reset
    parameter logic [31:0] INIT_PC = 32'h1c00_0000;

    // btb and bht share one index, 64 entries
    parameter int BTB_IDX_LEN = 6;

    parameter int TAG_LEN = 6; // tag bits above both hash fields

    // per-entry local history, needs at least 2 bits
    parameter int HIST_LEN = 4;

    // low pc bits (from bit 2 up) appended to the history for the pht
    parameter int PHT_PC_LEN = 4;

    // return stack entries, keep it a power of two
    // so the pointer wraps by itself
    parameter int RAS_DEPTH = 8;

endpackage

/* design/bpu_pkg.sv */
package bpu_pkg;

    // branch kind as reported by the backend and kept in the btb
    typedef enum logic [2:0] {
        BR_NPC  = 3'd0, // plain instruction
        BR_COND = 3'd1, // beq bne blt bge bltu bgeu
        BR_CALL = 3'd2, // bl, pushes pc + 4
        BR_RET  = 3'd3, // jirl used as return
        BR_JUMP = 3'd4  // b, always taken
    } br_type_e;

    // 2-bit saturating counter, one step toward the outcome
    function automatic logic [1:0] next_scnt(input logic [1:0] cnt, input logic taken);
        logic [1:0] res;
        res = cnt;
        if (taken && cnt != 2'b11) begin
            res = cnt + 2'b01;
        end else if (!taken && cnt != 2'b00) begin
            res = cnt - 2'b01;
        end
        return res;
    endfunction

    // index = pc[2 +: len] ^ pc[2+len +: len], result in the low len bits
    function automatic logic [31:0] btb_index(input logic [31:0] pc, input int idx_len);
        logic [31:0] res;
        res = '0;
        for (int i = 0; i < 15; i++) begin
            if (i < idx_len) begin
                res[i] = pc[2 + i] ^ pc[2 + idx_len + i];
            end
        end
        return res;
    endfunction

    // tag sits directly above both index fields
    function automatic logic [31:0] btb_tag(input logic [31:0] pc, input int idx_len,
                                            input int tag_len);
        logic [31:0] res;
        res = '0;
        for (int i = 0; i < 30; i++) begin
            if (i < tag_len && (2 + 2 * idx_len + i) < 32) begin
                res[i] = pc[2 + 2 * idx_len + i];
            end
        end
        return res;
    endfunction

endpackage

/* design/bpu_corr_decode.sv */
`timescale 1ns/100ps

module bpu_corr_decode (
    input  logic              clk,
    input  logic              rst_n,
    // backend correction, single-cycle pulse
    input  logic              corr_valid_i,
    input  logic [31:0]       corr_pc_i,
    input  bpu_pkg::br_type_e corr_br_type_i,
    input  logic              corr_taken_i,
    input  logic [31:0]       corr_target_i,
    input  logic              corr_redirect_i,
    // held copy, valid for one cycle
    output logic              upd_valid_o,
    output logic [31:0]       upd_pc_o,
    output bpu_pkg::br_type_e upd_type_o,
    output logic              upd_taken_o,
    output logic [31:0]       upd_target_o,
    // decoded actions
    output logic              btb_we_o,
    output logic              hist_we_o,
    output logic              ras_push_o,
    output logic              ras_pop_o,
    output logic              redir_valid_o,
    output logic [31:0]       redir_pc_o
);

    logic upd_redirect; // redirect request travelling with the payload

    // only the valid flag needs a reset, payload follows it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            upd_valid_o <= 1'b0;
        end else begin
            upd_valid_o <= corr_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        upd_pc_o     <= corr_pc_i;
        upd_type_o   <= corr_br_type_i;
        upd_taken_o  <= corr_taken_i;
        upd_target_o <= corr_target_i;
        upd_redirect <= corr_redirect_i;
    end

    assign btb_we_o   = upd_valid_o && (upd_type_o != bpu_pkg::BR_NPC); // any real branch
    assign hist_we_o  = upd_valid_o && (upd_type_o == bpu_pkg::BR_COND); // counters: cond only
    assign ras_push_o = upd_valid_o && (upd_type_o == bpu_pkg::BR_CALL);
    assign ras_pop_o  = upd_valid_o && (upd_type_o == bpu_pkg::BR_RET);

    // fall-through when resolved not taken
    assign redir_valid_o = upd_valid_o && upd_redirect;
    assign redir_pc_o    = upd_taken_o ? upd_target_o : upd_pc_o + 32'd4;

    // stack sees at most one operation per cycle
    a_push_pop_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(ras_push_o && ras_pop_o));

endmodule

/* design/bpu_tables.sv */
`timescale 1ns/100ps

module bpu_tables #(
    parameter int BTB_IDX_LEN = bpu_cfg_pkg::BTB_IDX_LEN,
    parameter int TAG_LEN     = bpu_cfg_pkg::TAG_LEN,
    parameter int HIST_LEN    = bpu_cfg_pkg::HIST_LEN,
    parameter int PHT_PC_LEN  = bpu_cfg_pkg::PHT_PC_LEN
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [31:0]       fetch_pc_i,   // lookup side
    input  logic [31:0]       upd_pc_i,     // training side
    input  bpu_pkg::br_type_e upd_type_i,
    input  logic              upd_taken_i,
    input  logic [31:0]       upd_target_i,
    input  logic              btb_we_i,
    input  logic              hist_we_i,
    output logic              hit_o,
    output bpu_pkg::br_type_e hit_type_o,
    output logic [31:0]       hit_target_o,
    output logic              cnt_taken_o
);

    localparam int BTB_DEPTH   = 1 << BTB_IDX_LEN;
    localparam int PHT_IDX_LEN = HIST_LEN + PHT_PC_LEN; // {history, pc bits}
    localparam int PHT_DEPTH   = 1 << PHT_IDX_LEN;

    // btb, valid bits are the only reset state
    logic              btb_valid  [BTB_DEPTH];
    logic [TAG_LEN-1:0] btb_tag   [BTB_DEPTH];
    bpu_pkg::br_type_e btb_type   [BTB_DEPTH];
    logic [31:0]       btb_target [BTB_DEPTH];
    // local history, one per btb entry
    logic [HIST_LEN-1:0] bht [BTB_DEPTH];
    // 2-bit counters
    logic [1:0] pht [PHT_DEPTH];

    logic [31:0]            rd_hash;
    logic [31:0]            rd_tag_full;
    logic [BTB_IDX_LEN-1:0] rd_idx;
    logic [PHT_IDX_LEN-1:0] rd_pht_idx;

    logic [31:0]            wr_hash;
    logic [31:0]            wr_tag_full;
    logic [BTB_IDX_LEN-1:0] wr_idx;
    logic                   wr_match;    // same entry already in the btb
    logic [HIST_LEN-1:0]    wr_hist_old; // history before this update
    logic [HIST_LEN-1:0]    wr_hist_new;
    logic [PHT_IDX_LEN-1:0] wr_pht_idx;

    // fetch lookup, all combinational
    assign rd_hash     = bpu_pkg::btb_index(fetch_pc_i, BTB_IDX_LEN);
    assign rd_tag_full = bpu_pkg::btb_tag(fetch_pc_i, BTB_IDX_LEN, TAG_LEN);
    assign rd_idx      = rd_hash[BTB_IDX_LEN-1:0];

    assign hit_o        = btb_valid[rd_idx] && (btb_tag[rd_idx] == rd_tag_full[TAG_LEN-1:0]);
    assign hit_type_o   = btb_type[rd_idx];   // only meaningful on a hit
    assign hit_target_o = btb_target[rd_idx];

    assign rd_pht_idx  = {bht[rd_idx], fetch_pc_i[PHT_PC_LEN+1:2]};
    assign cnt_taken_o = pht[rd_pht_idx][1]; // msb = predict taken

    // update side
    assign wr_hash     = bpu_pkg::btb_index(upd_pc_i, BTB_IDX_LEN);
    assign wr_tag_full = bpu_pkg::btb_tag(upd_pc_i, BTB_IDX_LEN, TAG_LEN);
    assign wr_idx      = wr_hash[BTB_IDX_LEN-1:0];
    assign wr_match    = btb_valid[wr_idx] && (btb_tag[wr_idx] == wr_tag_full[TAG_LEN-1:0]);

    // a fresh entry starts from an empty history
    // so a shift gives just the taken bit
    assign wr_hist_old = wr_match ? bht[wr_idx] : '0;
    assign wr_hist_new = {wr_hist_old[HIST_LEN-2:0], upd_taken_i};
    assign wr_pht_idx  = {wr_hist_old, upd_pc_i[PHT_PC_LEN+1:2]};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < BTB_DEPTH; i++) begin
                btb_valid[i] <= 1'b0;
                bht[i]       <= '0;
            end
            for (int j = 0; j < PHT_DEPTH; j++) begin
                pht[j] <= 2'b00;
            end
        end else begin
            if (btb_we_i) begin
                btb_valid[wr_idx] <= 1'b1;
                if (!wr_match || hist_we_i) begin // allocate or train
                    bht[wr_idx] <= wr_hist_new;
                end
            end
            if (hist_we_i) begin
                pht[wr_pht_idx] <= bpu_pkg::next_scnt(pht[wr_pht_idx], upd_taken_i);
            end
        end
    end

    // entry payload, overwritten on every btb write
    always_ff @(posedge clk) begin
        if (btb_we_i) begin
            btb_tag[wr_idx]    <= wr_tag_full[TAG_LEN-1:0];
            btb_type[wr_idx]   <= upd_type_i;
            btb_target[wr_idx] <= upd_target_i;
        end
    end

    // decode only trains history for entries it also writes
    a_hist_needs_btb: assert property (@(posedge clk) disable iff (!rst_n)
        hist_we_i |-> btb_we_i);

endmodule

/* design/bpu_ras.sv */
`timescale 1ns/100ps

module bpu_ras #(
    parameter int RAS_DEPTH = bpu_cfg_pkg::RAS_DEPTH
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        push_i,
    input  logic        pop_i,
    input  logic [31:0] call_pc_i, // pc of the call itself
    output logic [31:0] top_o
);

    localparam int PTR_LEN = $clog2(RAS_DEPTH);

    logic [31:0]        stack [RAS_DEPTH];
    logic [PTR_LEN-1:0] top_ptr;  // points at the current top
    logic [PTR_LEN-1:0] push_ptr; // slot above the top

    assign push_ptr = top_ptr + 1'b1; // wraps onto the oldest entry

    // all ones means empty so the first push lands in slot 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            top_ptr <= '1;
        end else if (push_i) begin
            top_ptr <= push_ptr;
        end else if (pop_i) begin
            top_ptr <= top_ptr - 1'b1; // no underflow guard
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            stack[push_ptr] <= call_pc_i + 32'd4; // return address
        end
    end

    assign top_o = stack[top_ptr];

endmodule

/* design/bpu_npc_select.sv */
`timescale 1ns/100ps

module bpu_npc_select #(
    parameter logic [31:0] INIT_PC = bpu_cfg_pkg::INIT_PC
) (
    input  logic              clk,
    input  logic              rst_n,
    // table and stack lookup for the current pc
    input  logic              hit_i,
    input  bpu_pkg::br_type_e hit_type_i,
    input  logic [31:0]       hit_target_i,
    input  logic              cnt_taken_i,
    input  logic [31:0]       ras_top_i,
    // backend redirect
    input  logic              redir_valid_i,
    input  logic [31:0]       redir_pc_i,
    // prediction sender
    output logic              pred_valid_o,
    input  logic              pred_ready_i,
    output logic [31:0]       pred_pc_o,
    output logic [31:0]       pred_npc_o,
    output logic              pred_taken_o,
    output bpu_pkg::br_type_e pred_br_type_o
);

    logic [31:0] pc_q;
    logic        valid_q;
    logic [31:0] seq_pc; // fall-through
    logic        fire;   // transfer this cycle

    assign seq_pc = pc_q + 32'd4;
    assign fire   = valid_q && pred_ready_i;

    always_comb begin
        pred_taken_o = 1'b0;
        pred_npc_o   = seq_pc;
        if (hit_i) begin
            case (hit_type_i)
                bpu_pkg::BR_JUMP, bpu_pkg::BR_CALL: begin
                    pred_taken_o = 1'b1;
                    pred_npc_o   = hit_target_i;
                end
                bpu_pkg::BR_RET: begin // target comes from the stack
                    pred_taken_o = 1'b1;
                    pred_npc_o   = ras_top_i;
                end
                bpu_pkg::BR_COND: begin
                    pred_taken_o = cnt_taken_i;
                    pred_npc_o   = cnt_taken_i ? hit_target_i : seq_pc;
                end
                default: begin
                    pred_taken_o = 1'b0;
                    pred_npc_o   = seq_pc;
                end
            endcase
        end
    end

    assign pred_br_type_o = hit_i ? hit_type_i : bpu_pkg::BR_NPC;
    assign pred_pc_o      = pc_q;
    assign pred_valid_o   = valid_q;

    // redirect wins over a transfer, the offered pc is dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q    <= INIT_PC;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b1; // up from the first cycle after reset
            if (redir_valid_i) begin
                pc_q <= redir_pc_i;
            end else if (fire) begin
                pc_q <= pred_npc_o;
            end
        end
    end

    // back-pressure holds the offered pc
    a_pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
        pred_valid_o && !pred_ready_i && !redir_valid_i |=> $stable(pc_q));

endmodule

/* design/bpu_top.sv */
`timescale 1ns/100ps

module bpu_top #(
    parameter logic [31:0] INIT_PC     = bpu_cfg_pkg::INIT_PC,
    parameter int          BTB_IDX_LEN = bpu_cfg_pkg::BTB_IDX_LEN,
    parameter int          TAG_LEN     = bpu_cfg_pkg::TAG_LEN,
    parameter int          HIST_LEN    = bpu_cfg_pkg::HIST_LEN,
    parameter int          PHT_PC_LEN  = bpu_cfg_pkg::PHT_PC_LEN,
    parameter int          RAS_DEPTH   = bpu_cfg_pkg::RAS_DEPTH
) (
    input  logic              clk,
    input  logic              rst_n,
    // fetch sender
    output logic              pred_valid_o,
    input  logic              pred_ready_i,
    output logic [31:0]       pred_pc_o,
    output logic [31:0]       pred_npc_o,
    output logic              pred_taken_o,
    output bpu_pkg::br_type_e pred_br_type_o,
    // backend correction
    input  logic              corr_valid_i,
    input  logic [31:0]       corr_pc_i,
    input  bpu_pkg::br_type_e corr_br_type_i,
    input  logic              corr_taken_i,
    input  logic [31:0]       corr_target_i,
    input  logic              corr_redirect_i
);

    // decode outputs
    logic [31:0]       upd_pc;
    bpu_pkg::br_type_e upd_type;
    logic              upd_taken;
    logic [31:0]       upd_target;
    logic              btb_we;
    logic              hist_we;
    logic              ras_push;
    logic              ras_pop;
    logic              redir_valid;
    logic [31:0]       redir_pc;
    // lookup results
    logic              hit;
    bpu_pkg::br_type_e hit_type;
    logic [31:0]       hit_target;
    logic              cnt_taken;
    logic [31:0]       ras_top;

    bpu_corr_decode u_decode (
        .clk(clk), .rst_n(rst_n),
        .corr_valid_i(corr_valid_i), .corr_pc_i(corr_pc_i), .corr_br_type_i(corr_br_type_i),
        .corr_taken_i(corr_taken_i), .corr_target_i(corr_target_i),
        .corr_redirect_i(corr_redirect_i),
        .upd_valid_o(), // enables already carry the valid
        .upd_pc_o(upd_pc), .upd_type_o(upd_type), .upd_taken_o(upd_taken),
        .upd_target_o(upd_target), .btb_we_o(btb_we), .hist_we_o(hist_we),
        .ras_push_o(ras_push), .ras_pop_o(ras_pop),
        .redir_valid_o(redir_valid), .redir_pc_o(redir_pc)
    );

    bpu_tables #(
        .BTB_IDX_LEN(BTB_IDX_LEN), .TAG_LEN(TAG_LEN),
        .HIST_LEN(HIST_LEN), .PHT_PC_LEN(PHT_PC_LEN)
    ) u_tables (
        .clk(clk), .rst_n(rst_n), .fetch_pc_i(pred_pc_o),
        .upd_pc_i(upd_pc), .upd_type_i(upd_type), .upd_taken_i(upd_taken),
        .upd_target_i(upd_target), .btb_we_i(btb_we), .hist_we_i(hist_we),
        .hit_o(hit), .hit_type_o(hit_type), .hit_target_o(hit_target),
        .cnt_taken_o(cnt_taken)
    );

    bpu_ras #(.RAS_DEPTH(RAS_DEPTH)) u_ras (
        .clk(clk), .rst_n(rst_n), .push_i(ras_push), .pop_i(ras_pop),
        .call_pc_i(upd_pc), .top_o(ras_top)
    );

    bpu_npc_select #(.INIT_PC(INIT_PC)) u_npc (
        .clk(clk), .rst_n(rst_n),
        .hit_i(hit), .hit_type_i(hit_type), .hit_target_i(hit_target),
        .cnt_taken_i(cnt_taken), .ras_top_i(ras_top),
        .redir_valid_i(redir_valid), .redir_pc_i(redir_pc),
        .pred_valid_o(pred_valid_o), .pred_ready_i(pred_ready_i), .pred_pc_o(pred_pc_o),
        .pred_npc_o(pred_npc_o), .pred_taken_o(pred_taken_o),
        .pred_br_type_o(pred_br_type_o)
    );

endmodule

/* verification/bpu_clk_gen.sv */
`timescale 1ns/100ps

module bpu_clk_gen #(
    parameter int HALF_PERIOD_NS = 4,  // 8 ns clock
    parameter int RESET_CYCLES   = 10
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    // released 1 ns after an edge, like the stimulus
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

/* verification/bpu_tb.sv */
`timescale 1ns/100ps

module bpu_tb;

    localparam int RESET_CYCLES = 10;
    localparam int MAX_STALL    = 6;  // ready forced high after this many low cycles
    localparam int ROW_CYCLES   = 10; // watchdog budget per row

    // index is pc[7:2] ^ pc[13:8] and tag is pc[19:14]
    // each branch gets its own index
    localparam logic [31:0] INIT   = bpu_cfg_pkg::INIT_PC;
    localparam logic [31:0] PC_A   = 32'h1c00_0100; // index 1 tag 0
    localparam logic [31:0] TGT_A  = 32'h1c00_0900;
    localparam logic [31:0] PC_J   = 32'h1c00_0200; // index 2
    localparam logic [31:0] TGT_J  = 32'h1c00_0800; // index 8 and never trained
    localparam logic [31:0] PC_C0  = 32'h1c00_0300;
    localparam logic [31:0] TGT_C0 = 32'h1c00_2000;
    localparam logic [31:0] PC_R   = 32'h1c00_0500; // the return
    localparam logic [31:0] PC_C1  = 32'h1c00_0600;
    localparam logic [31:0] TGT_C1 = 32'h1c00_3000;
    localparam logic [31:0] PC_C2  = 32'h1c00_0700;
    localparam logic [31:0] TGT_C2 = 32'h1c00_3100;
    localparam logic [31:0] PC_AX  = 32'h1c00_4100; // index 1 again with tag 1
    localparam logic [31:0] TGT_AX = 32'h1c00_0a00;

    localparam bpu_pkg::br_type_e K_NPC  = bpu_pkg::BR_NPC;
    localparam bpu_pkg::br_type_e K_COND = bpu_pkg::BR_COND;
    localparam bpu_pkg::br_type_e K_CALL = bpu_pkg::BR_CALL;
    localparam bpu_pkg::br_type_e K_RET  = bpu_pkg::BR_RET;
    localparam bpu_pkg::br_type_e K_JUMP = bpu_pkg::BR_JUMP;

    typedef enum {ACT_CORR, ACT_REDIR, ACT_FETCH} act_e;

    typedef struct {
        string             name;
        act_e              act;
        logic [31:0]       pc;     // correction payload
        bpu_pkg::br_type_e kind;
        logic              taken;
        logic [31:0]       target;
        logic              ready;  // low gives random stalls before the transfer
        logic [31:0]       exp_pc;
        logic [31:0]       exp_npc;
        logic              exp_taken;
        bpu_pkg::br_type_e exp_kind;
    } row_t;

    logic              clk;
    logic              rst_n;
    logic              pred_valid;
    logic              pred_ready;
    logic [31:0]       pred_pc;
    logic [31:0]       pred_npc;
    logic              pred_taken;
    bpu_pkg::br_type_e pred_kind;
    logic              corr_valid;
    logic [31:0]       corr_pc;
    bpu_pkg::br_type_e corr_kind;
    logic              corr_taken;
    logic [31:0]       corr_target;
    logic              corr_redirect;

    row_t   rows[$];
    string  cur_name;
    int     row_errs;
    int     total_errs;
    int     rows_passed;
    int     rows_failed;
    integer seed;
    bit     table_done;

    bpu_clk_gen #(.HALF_PERIOD_NS(4), .RESET_CYCLES(RESET_CYCLES)) u_clk (
        .clk_o(clk), .rst_n_o(rst_n)
    );

    bpu_top #(
        .INIT_PC(bpu_cfg_pkg::INIT_PC), .BTB_IDX_LEN(bpu_cfg_pkg::BTB_IDX_LEN),
        .TAG_LEN(bpu_cfg_pkg::TAG_LEN), .HIST_LEN(bpu_cfg_pkg::HIST_LEN),
        .PHT_PC_LEN(bpu_cfg_pkg::PHT_PC_LEN), .RAS_DEPTH(bpu_cfg_pkg::RAS_DEPTH)
    ) UUT (
        .clk(clk), .rst_n(rst_n),
        .pred_valid_o(pred_valid), .pred_ready_i(pred_ready), .pred_pc_o(pred_pc),
        .pred_npc_o(pred_npc), .pred_taken_o(pred_taken), .pred_br_type_o(pred_kind),
        .corr_valid_i(corr_valid), .corr_pc_i(corr_pc), .corr_br_type_i(corr_kind),
        .corr_taken_i(corr_taken), .corr_target_i(corr_target),
        .corr_redirect_i(corr_redirect)
    );

    function automatic row_t blank_row(input string name, input act_e act);
        row_t r;
        r.name      = name;
        r.act       = act;
        r.pc        = '0;
        r.kind      = K_NPC;
        r.taken     = 1'b0;
        r.target    = '0;
        r.ready     = 1'b0; // hold the pc while corrections go in
        r.exp_pc    = '0;
        r.exp_npc   = '0;
        r.exp_taken = 1'b0;
        r.exp_kind  = K_NPC;
        return r;
    endfunction

    function automatic void fetch_row(input string name, input logic ready,
                                      input logic [31:0] exp_pc, input logic [31:0] exp_npc,
                                      input logic exp_taken, input bpu_pkg::br_type_e exp_kind);
        row_t r;
        r = blank_row(name, ACT_FETCH);
        r.ready     = ready;
        r.exp_pc    = exp_pc;
        r.exp_npc   = exp_npc;
        r.exp_taken = exp_taken;
        r.exp_kind  = exp_kind;
        rows.push_back(r);
    endfunction

    // pc must not move while a plain correction trains the tables
    function automatic void corr_row(input string name, input logic [31:0] pc,
                                     input bpu_pkg::br_type_e kind, input logic taken,
                                     input logic [31:0] target, input logic [31:0] exp_pc);
        row_t r;
        r = blank_row(name, ACT_CORR);
        r.pc     = pc;
        r.kind   = kind;
        r.taken  = taken;
        r.target = target;
        r.exp_pc = exp_pc;
        rows.push_back(r);
    endfunction

    function automatic void redir_row(input string name, input logic [31:0] pc,
                                      input bpu_pkg::br_type_e kind, input logic taken,
                                      input logic [31:0] target, input logic [31:0] exp_pc,
                                      input logic [31:0] exp_npc, input logic exp_taken,
                                      input bpu_pkg::br_type_e exp_kind);
        row_t r;
        r = blank_row(name, ACT_REDIR);
        r.pc        = pc;
        r.kind      = kind;
        r.taken     = taken;
        r.target    = target;
        r.exp_pc    = exp_pc;
        r.exp_npc   = exp_npc;
        r.exp_taken = exp_taken;
        r.exp_kind  = exp_kind;
        rows.push_back(r);
    endfunction

    // non-branch redirect that moves the pc without training anything
    function automatic void goto_row(input string name, input logic [31:0] dest,
                                     input logic [31:0] exp_npc, input logic exp_taken,
                                     input bpu_pkg::br_type_e exp_kind);
        redir_row(name, 32'h0, K_NPC, 1'b1, dest, dest, exp_npc, exp_taken, exp_kind);
    endfunction

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %s %s expected %h actual %h", cur_name, what, exp, act);
            row_errs++;
        end
    endtask

    task automatic check_payload(input row_t r);
        check_val("valid", 32'd1, {31'd0, pred_valid});
        check_val("pc", r.exp_pc, pred_pc);
        check_val("npc", r.exp_npc, pred_npc);
        check_val("taken", {31'd0, r.exp_taken}, {31'd0, pred_taken});
        check_val("kind", 32'(r.exp_kind), 32'(pred_kind));
    endtask

    // pulse sampled at edge N and applied at N+1
    task automatic send_correction(input row_t r, input logic redirect);
        corr_valid    = 1'b1;
        corr_pc       = r.pc;
        corr_kind     = r.kind;
        corr_taken    = r.taken;
        corr_target   = r.target;
        corr_redirect = redirect;
        @(posedge clk);
        #1;
        corr_valid    = 1'b0;
        corr_redirect = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic fetch_and_check(input row_t r);
        logic ready_bit;
        int   waited;
        int   stalls;
        int   rnd;
        waited = 0;
        while (pred_valid !== 1'b1 && waited < 4) begin // valid rises right after reset
            @(posedge clk);
            #1;
            waited++;
        end
        assert (pred_valid === 1'b1) else begin
            $display("%s: the fetch sender never raised valid", cur_name);
            row_errs++;
        end
        if (!r.ready) begin
            stalls    = 0;
            ready_bit = 1'b0; // at least one stalled edge
            while (!ready_bit) begin
                pred_ready = 1'b0;
                @(posedge clk);
                #1;
                check_val("held pc", r.exp_pc, pred_pc);
                check_val("held npc", r.exp_npc, pred_npc);
                check_val("held taken", {31'd0, r.exp_taken}, {31'd0, pred_taken});
                check_val("held kind", 32'(r.exp_kind), 32'(pred_kind));
                stalls++;
                rnd       = $random(seed);
                ready_bit = (stalls >= MAX_STALL) ? 1'b1 : rnd[0];
            end
        end
        check_payload(r);
        pred_ready = 1'b1; // one transfer
        @(posedge clk);
        #1;
        pred_ready = 1'b0;
    endtask

    initial begin
        wait (table_done);
        repeat (rows.size() * ROW_CYCLES + RESET_CYCLES + 10) @(posedge clk);
        $display("watchdog: the run took longer than its cycle budget and was stopped");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        pred_ready    = 1'b0;
        corr_valid    = 1'b0;
        corr_pc       = '0;
        corr_kind     = K_NPC;
        corr_taken    = 1'b0;
        corr_target   = '0;
        corr_redirect = 1'b0;
        seed          = 32420;
        total_errs    = 0;
        rows_passed   = 0;
        rows_failed   = 0;

        // pc walks by 4 through empty tables
        fetch_row("seq_0", 1'b1, INIT, INIT + 32'h4, 1'b0, K_NPC);
        fetch_row("seq_1", 1'b1, INIT + 32'h4, INIT + 32'h8, 1'b0, K_NPC);
        fetch_row("seq_2", 1'b1, INIT + 32'h8, INIT + 32'hc, 1'b0, K_NPC);
        fetch_row("stall_0", 1'b0, INIT + 32'hc, INIT + 32'h10, 1'b0, K_NPC);
        fetch_row("stall_1", 1'b0, INIT + 32'h10, INIT + 32'h14, 1'b0, K_NPC);
        fetch_row("stall_2", 1'b0, INIT + 32'h14, INIT + 32'h18, 1'b0, K_NPC);
        // history walks 0001 0011 0111 1111 while counters step up from 0
        corr_row("cond_t1", PC_A, K_COND, 1'b1, TGT_A, INIT + 32'h18);
        goto_row("cond_chk1", PC_A, PC_A + 32'h4, 1'b0, K_COND); // pht[0001_0000] = 0
        corr_row("cond_t2", PC_A, K_COND, 1'b1, TGT_A, PC_A);
        corr_row("cond_t3", PC_A, K_COND, 1'b1, TGT_A, PC_A);
        corr_row("cond_t4", PC_A, K_COND, 1'b1, TGT_A, PC_A);
        corr_row("cond_t5", PC_A, K_COND, 1'b1, TGT_A, PC_A);
        corr_row("cond_t6", PC_A, K_COND, 1'b1, TGT_A, PC_A);
        goto_row("cond_chk6", PC_A, TGT_A, 1'b1, K_COND); // pht[1111_0000] = 2
        corr_row("cond_n1", PC_A, K_COND, 1'b0, TGT_A, PC_A);
        corr_row("cond_n2", PC_A, K_COND, 1'b0, TGT_A, PC_A);
        goto_row("cond_chkn", PC_A, PC_A + 32'h4, 1'b0, K_COND); // history 1100 with counter 0
        redir_row("jump_redir", PC_J, K_JUMP, 1'b1, TGT_J, TGT_J,
                  TGT_J + 32'h4, 1'b0, K_NPC);
        goto_row("jump_chk", PC_J, TGT_J, 1'b1, K_JUMP);
        fetch_row("jump_fetch", 1'b1, PC_J, TGT_J, 1'b1, K_JUMP);
        fetch_row("jump_land", 1'b1, TGT_J, TGT_J + 32'h4, 1'b0, K_NPC);
        // ret entry trained after a call so the pop never hits an empty stack
        corr_row("call_c0", PC_C0, K_CALL, 1'b1, TGT_C0, TGT_J + 32'h4);
        corr_row("ret_train", PC_R, K_RET, 1'b1, PC_C0 + 32'h4, TGT_J + 32'h4);
        corr_row("call_c1", PC_C1, K_CALL, 1'b1, TGT_C1, TGT_J + 32'h4);
        corr_row("call_c2", PC_C2, K_CALL, 1'b1, TGT_C2, TGT_J + 32'h4);
        goto_row("ret_chk2", PC_R, PC_C2 + 32'h4, 1'b1, K_RET);
        corr_row("ret_pop2", PC_R, K_RET, 1'b1, PC_C2 + 32'h4, PC_R);
        fetch_row("ret_chk1", 1'b1, PC_R, PC_C1 + 32'h4, 1'b1, K_RET);
        // tag mismatch on A's index
        goto_row("alias_miss", PC_AX, PC_AX + 32'h4, 1'b0, K_NPC);
        corr_row("alias_write", PC_AX, K_COND, 1'b1, TGT_AX, PC_AX);
        goto_row("alias_chk", PC_AX, PC_AX + 32'h4, 1'b0, K_COND); // history 0001 again
        goto_row("alias_old", PC_A, PC_A + 32'h4, 1'b0, K_NPC);    // A evicted
        table_done = 1'b1;

        wait (rst_n === 1'b1);
        foreach (rows[i]) begin
            cur_name = rows[i].name;
            row_errs = 0;
            case (rows[i].act)
                ACT_CORR: begin
                    send_correction(rows[i], 1'b0);
                    check_val("pc", rows[i].exp_pc, pred_pc); // ready is low so the pc holds
                end
                ACT_REDIR: begin
                    send_correction(rows[i], 1'b1);
                    check_payload(rows[i]);
                end
                default: begin
                    fetch_and_check(rows[i]);
                end
            endcase
            total_errs += row_errs;
            if (row_errs == 0) begin
                rows_passed++;
                $display("row %0d %s passed", i, cur_name);
            end else begin
                rows_failed++;
                $display("row %0d %s failed with %0d errors", i, cur_name, row_errs);
            end
        end

        $display("rows %0d, passed %0d, failed %0d, failed checks %0d",
                 rows.size(), rows_passed, rows_failed, total_errs);
        if (rows_failed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
design/bpu_cfg_pkg.sv
design/bpu_pkg.sv
design/bpu_corr_decode.sv
design/bpu_tables.sv
design/bpu_ras.sv
design/bpu_npc_select.sv
design/bpu_top.sv
verification/bpu_clk_gen.sv
verification/bpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the branch predictor testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal --top-module bpu_tb \
    -f sim.f -o bpu_sim > "$BUILD_LOG" 2>&1
build_status=$?
if [ "$build_status" -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/bpu_sim > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"
if [ "$run_status" -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

# the log decides the result
if grep -q "SIMULATION FAILED" "$SIM_LOG"; then
    exit 1
fi
if ! grep -q "SIMULATION PASSED" "$SIM_LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
